/* hdl/nabp_pkg.sv */
`default_nettype none

package nabp_pkg;

    // line and run geometry
    localparam int LINE_LEN   = 8;
    localparam int NUM_ANGLES = 4;

    // datapath widths
    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 12;
    localparam int OFFS_W   = $clog2(LINE_LEN);
    localparam int ANGLE_W  = $clog2(NUM_ANGLES);

    // one projection sample
    typedef logic [SAMPLE_W-1:0] sample_t;

    // rotation of the detector line, also the shifter read start
    typedef logic [OFFS_W-1:0] offset_t;

    // pixel address, wraps modulo 2**ADDR_W
    typedef logic [ADDR_W-1:0] addr_t;

    // per-angle parameter set held in the table
    typedef struct packed {
        offset_t sh_accu_base;
        addr_t   mp_accu_init;
        addr_t   mp_accu_base;
    } angle_param_t;

    // one update leaving towards the pixel memory
    typedef struct packed {
        addr_t   addr;
        sample_t value;
    } pixel_update_t;

    // controller states
    typedef enum logic [1:0] {
        READY     = 2'd0,
        FILL      = 2'd1,
        FILL_DONE = 2'd2,
        SHIFT     = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/nabp_swap_control.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_swap_control
    import nabp_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,
    // configuration port
    input  wire                 cfg_valid,
    input  wire [ANGLE_W-1:0]   cfg_index,
    input  angle_param_t        cfg_param,
    // run control
    input  wire                 start,
    // requests from state control
    input  wire                 sw_next_itr,
    input  wire                 sw_swap,
    // answers to state control
    output logic                sw_next_itr_ack,
    output logic                sw_swap_ack,
    output angle_param_t        sw_param,
    output logic                run_last
);

    // per-angle parameter table
    angle_param_t         param_table [NUM_ANGLES];

    logic                 run_active;
    logic [ANGLE_W-1:0]   angle;
    logic                 angle_is_last;

    assign angle_is_last = (angle == ANGLE_W'(NUM_ANGLES - 1));

    // table writes only outside a run
    always_ff @(posedge clk)
    begin
        if (cfg_valid && !run_active)
        begin
            param_table[cfg_index] <= cfg_param;
        end
    end

    // run flag and angle counter
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            run_active <= 1'b0;
            angle      <= '0;
        end
        else if (start)
        begin
            run_active <= 1'b1;
            angle      <= '0;
        end
        else if (sw_swap_ack)
        begin
            // counter parks on the final angle so run_last covers its shift
            if (angle_is_last)
                run_active <= 1'b0;
            else
                angle <= angle + 1'b1;
        end
    end

    // swap ack one cycle after the request, single pulse
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            sw_swap_ack <= 1'b0;
        else
            sw_swap_ack <= sw_swap && !sw_swap_ack;
    end

    // iteration ack while angles remain
    assign sw_next_itr_ack = run_active && sw_next_itr;

    // parameters of the angle being served
    assign sw_param = param_table[angle];

    // final angle swapped in and run closed, so the shift in progress is the last
    assign run_last = angle_is_last && !run_active;

endmodule

`default_nettype wire

/* hdl/nabp_state_control.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_state_control
    import nabp_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,
    // from swap control
    input  angle_param_t    sw_param,
    input  wire             sw_next_itr_ack,
    input  wire             sw_swap_ack,
    // from shifter
    input  wire             sh_fill_done,
    input  wire             sh_shift_done,
    // final angle of the run in progress
    input  wire             run_last,
    // to swap control
    output logic            sw_next_itr,
    output logic            sw_swap,
    // to shifter
    output logic            sh_fill_kick,
    output logic            sh_shift_kick,
    output offset_t         sh_accu_base,
    // to mapper
    output addr_t           mp_accu_init,
    output addr_t           mp_accu_base,
    // end of run
    output logic            done
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        done_pend;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= READY;
        else
            state <= next_state;
    end

    // keep refreshing while idle, last value is the one from the ack cycle
    always_ff @(posedge clk)
    begin
        if (state == READY)
        begin
            sh_accu_base <= sw_param.sh_accu_base;
            mp_accu_init <= sw_param.mp_accu_init;
            mp_accu_base <= sw_param.mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        unique case (state)
            READY:
                if (sw_next_itr_ack)
                    next_state = FILL;
            FILL:
                if (sh_fill_done)
                    next_state = FILL_DONE;
            FILL_DONE:
                if (sw_swap_ack)
                    next_state = SHIFT;
            SHIFT:
                if (sh_shift_done)
                    next_state = READY;
        endcase
    end

    // requests and kicks decoded from state and transition
    assign sw_next_itr   = reset_n && (state == READY);
    assign sw_swap       = (state == FILL_DONE);
    assign sh_fill_kick  = (state != FILL) && (next_state == FILL);
    assign sh_shift_kick = (state != SHIFT) && (next_state == SHIFT);

    // two stages so done trails the mapper's last update by a cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            done_pend <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            done_pend <= (state == SHIFT) && sh_shift_done && run_last;
            done      <= done_pend;
        end
    end

endmodule

`default_nettype wire

/* hdl/nabp_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_shifter
    import nabp_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    // phase kicks from state control
    input  wire         fill_kick,
    input  wire         shift_kick,
    input  offset_t     accu_base,
    // projection stream
    input  wire         proj_valid,
    input  sample_t     proj_sample,
    output logic        proj_ready,
    output logic        fill_done,
    // rotated line out
    output logic        sh_valid,
    output sample_t     sh_sample,
    output logic        shift_done
);

    sample_t    line_buf [LINE_LEN];

    offset_t    wr_ptr;
    offset_t    rd_ptr;
    offset_t    out_cnt;
    logic       shift_active;
    logic       accept;

    // samples outside the fill window are dropped here
    assign accept    = proj_ready && proj_valid;
    assign fill_done = accept && (wr_ptr == OFFS_W'(LINE_LEN - 1));

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            line_buf[wr_ptr] <= proj_sample;
        end
    end

    // fill phase
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            proj_ready <= 1'b0;
            wr_ptr     <= '0;
        end
        else if (fill_kick)
        begin
            proj_ready <= 1'b1;
            wr_ptr     <= '0;
        end
        else if (accept)
        begin
            wr_ptr <= wr_ptr + 1'b1;
            if (fill_done)
                proj_ready <= 1'b0;
        end
    end

    // shift phase, read pointer wraps around the line
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            shift_active <= 1'b0;
            rd_ptr       <= '0;
            out_cnt      <= '0;
        end
        else if (shift_kick)
        begin
            shift_active <= 1'b1;
            rd_ptr       <= accu_base;
            out_cnt      <= '0;
        end
        else if (shift_active)
        begin
            rd_ptr  <= rd_ptr + 1'b1;
            out_cnt <= out_cnt + 1'b1;
            if (shift_done)
                shift_active <= 1'b0;
        end
    end

    assign sh_valid   = shift_active;
    assign sh_sample  = line_buf[rd_ptr];
    assign shift_done = shift_active && (out_cnt == OFFS_W'(LINE_LEN - 1));

endmodule

`default_nettype wire

/* hdl/nabp_mapper.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_mapper
    import nabp_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,
    // per-angle address start and step
    input  addr_t           accu_init,
    input  addr_t           accu_base,
    // sample stream from the shifter
    input  wire             sh_valid,
    input  sample_t         sh_sample,
    // pixel updates
    output logic            pix_valid,
    output pixel_update_t   pix
);

    addr_t accu;

    // address accumulator, preloaded between lines
    always_ff @(posedge clk)
    begin
        if (sh_valid)
            accu <= accu + accu_base;
        else
            accu <= accu_init;
    end

    // update payload, current address before the step is added
    always_ff @(posedge clk)
    begin
        if (sh_valid)
        begin
            pix.addr  <= accu;
            pix.value <= sh_sample;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pix_valid <= 1'b0;
        else
            pix_valid <= sh_valid;
    end

endmodule

`default_nettype wire

/* hdl/nabp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_top
    import nabp_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,
    // configuration
    input  wire                 cfg_valid,
    input  wire [ANGLE_W-1:0]   cfg_index,
    input  angle_param_t        cfg_param,
    // run control
    input  wire                 start,
    output logic                done,
    // projection input
    output logic                proj_ready,
    input  wire                 proj_valid,
    input  sample_t             proj_sample,
    // pixel output
    output logic                pix_valid,
    output pixel_update_t       pix
);

    // swap control handshake
    logic           sw_next_itr;
    logic           sw_next_itr_ack;
    logic           sw_swap;
    logic           sw_swap_ack;
    angle_param_t   sw_param;
    logic           run_last;

    // shifter handshake
    logic           sh_fill_kick;
    logic           sh_shift_kick;
    logic           sh_fill_done;
    logic           sh_shift_done;
    offset_t        sh_accu_base;
    logic           sh_valid;
    sample_t        sh_sample;

    // mapper bases
    addr_t          mp_accu_init;
    addr_t          mp_accu_base;

    nabp_swap_control u_swap_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .cfg_valid       (cfg_valid),
        .cfg_index       (cfg_index),
        .cfg_param       (cfg_param),
        .start           (start),
        .sw_next_itr     (sw_next_itr),
        .sw_swap         (sw_swap),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sw_swap_ack     (sw_swap_ack),
        .sw_param        (sw_param),
        .run_last        (run_last)
    );

    nabp_state_control u_state_control (
        .clk             (clk),
        .reset_n         (reset_n),
        .sw_param        (sw_param),
        .sw_next_itr_ack (sw_next_itr_ack),
        .sw_swap_ack     (sw_swap_ack),
        .sh_fill_done    (sh_fill_done),
        .sh_shift_done   (sh_shift_done),
        .run_last        (run_last),
        .sw_next_itr     (sw_next_itr),
        .sw_swap         (sw_swap),
        .sh_fill_kick    (sh_fill_kick),
        .sh_shift_kick   (sh_shift_kick),
        .sh_accu_base    (sh_accu_base),
        .mp_accu_init    (mp_accu_init),
        .mp_accu_base    (mp_accu_base),
        .done            (done)
    );

    nabp_shifter u_shifter (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (sh_fill_kick),
        .shift_kick  (sh_shift_kick),
        .accu_base   (sh_accu_base),
        .proj_valid  (proj_valid),
        .proj_sample (proj_sample),
        .proj_ready  (proj_ready),
        .fill_done   (sh_fill_done),
        .sh_valid    (sh_valid),
        .sh_sample   (sh_sample),
        .shift_done  (sh_shift_done)
    );

    nabp_mapper u_mapper (
        .clk       (clk),
        .reset_n   (reset_n),
        .accu_init (mp_accu_init),
        .accu_base (mp_accu_base),
        .sh_valid  (sh_valid),
        .sh_sample (sh_sample),
        .pix_valid (pix_valid),
        .pix       (pix)
    );

endmodule

`default_nettype wire

/* dv/nabp_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nabp_tb
    import nabp_pkg::*;
();

    logic                clk;
    logic                reset_n;
    logic                cfg_valid;
    logic [ANGLE_W-1:0]  cfg_index;
    angle_param_t        cfg_param;
    logic                start;
    logic                done;
    logic                proj_ready;
    logic                proj_valid;
    sample_t             proj_sample;
    logic                pix_valid;
    pixel_update_t       pix;

    logic [31:0]         lfsr;
    angle_param_t        table_shadow [NUM_ANGLES];
    pixel_update_t       exp_q [$];
    pixel_update_t       exp_pix;
    int                  pix_total;
    int                  done_cnt;
    int                  runs_started;
    logic                run_started;
    logic                prev_pix_valid;

    nabp_top uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .cfg_valid   (cfg_valid),
        .cfg_index   (cfg_index),
        .cfg_param   (cfg_param),
        .start       (start),
        .done        (done),
        .proj_ready  (proj_ready),
        .proj_valid  (proj_valid),
        .proj_sample (proj_sample),
        .pix_valid   (pix_valid),
        .pix         (pix)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp)
            else abort_run($sformatf("Error at %0t: %s expected 0x%0h, actual 0x%0h",
                                     $time, name, exp, act));
    endtask

    task automatic expect_low(input string name, input logic value);
        assert (value === 1'b0)
            else abort_run($sformatf("Error at %0t: %s expected 0, actual %b",
                                     $time, name, value));
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic angle_param_t random_param();
        angle_param_t p;
        p.sh_accu_base = offset_t'(lfsr_bits(OFFS_W));
        p.mp_accu_init = addr_t'(lfsr_bits(ADDR_W));
        p.mp_accu_base = addr_t'(lfsr_bits(ADDR_W));
        return p;
    endfunction

    task automatic write_entry(input int index, input angle_param_t p);
        table_shadow[index] = p;
        cfg_valid = 1'b1;
        cfg_index = ANGLE_W'(index);
        cfg_param = p;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    // everything on the reset list, internal strobes included
    task automatic check_idle();
        expect_low("proj_ready", proj_ready);
        expect_low("pix_valid", pix_valid);
        expect_low("done", done);
        expect_low("sw_next_itr_ack", uut.sw_next_itr_ack);
        expect_low("sw_swap_ack", uut.sw_swap_ack);
        expect_low("sh_fill_kick", uut.sh_fill_kick);
        expect_low("sh_shift_kick", uut.sh_shift_kick);
        expect_low("sh_fill_done", uut.sh_fill_done);
        expect_low("sh_shift_done", uut.sh_shift_done);
        compare_value("state", READY, uut.u_state_control.state);
    endtask

    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        while (!proj_ready && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (proj_ready) else abort_run("timed out waiting for proj_ready");
    endtask

    task automatic wait_for_done(input int target);
        int cycles;
        cycles = 0;
        while (done_cnt < target && cycles < 200)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (done_cnt >= target) else abort_run("timed out waiting for done");
    endtask

    // one run over all angles, expected updates built from the table copy
    task automatic run_angles();
        int            a;
        int            k;
        int            gap;
        sample_t       line [LINE_LEN];
        angle_param_t  p;
        pixel_update_t upd;
        start        = 1'b1;
        run_started  = 1'b1;
        runs_started = runs_started + 1;
        @(negedge clk);
        start = 1'b0;
        for (a = 0; a < NUM_ANGLES; a++)
        begin
            wait_for_ready();
            for (k = 0; k < LINE_LEN; k++)
            begin
                gap        = int'(lfsr_bits(2));
                proj_valid = 1'b0;
                repeat (gap) @(negedge clk);
                proj_valid  = 1'b1;
                proj_sample = sample_t'(lfsr_bits(SAMPLE_W));
                line[k]     = proj_sample;
                @(negedge clk);
            end
            // strobes just after the line, proj_ready is already low
            proj_sample = sample_t'(lfsr_bits(SAMPLE_W));
            @(negedge clk);
            proj_sample = sample_t'(lfsr_bits(SAMPLE_W));
            @(negedge clk);
            proj_valid = 1'b0;
            p = table_shadow[a];
            for (k = 0; k < LINE_LEN; k++)
            begin
                upd.addr  = addr_t'((int'(p.mp_accu_init) + k * int'(p.mp_accu_base)) % 4096);
                upd.value = line[(int'(p.sh_accu_base) + k) % LINE_LEN];
                exp_q.push_back(upd);
            end
        end
        wait_for_done(runs_started);
    endtask

    // output monitor, sampled mid-cycle
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (!run_started)
                check_idle();
            assert (!pix_valid || prev_pix_valid || (pix_total % LINE_LEN) == 0)
                else abort_run("pixel updates of a line were not consecutive");
            assert (pix_valid || !prev_pix_valid || (pix_total % LINE_LEN) == 0)
                else abort_run("pixel update burst ended before the line was complete");
            if (pix_valid)
            begin
                assert (exp_q.size() != 0)
                    else abort_run("pixel update seen while none was expected");
                if (exp_q.size() != 0)
                begin
                    exp_pix = exp_q.pop_front();
                    compare_value("pix.addr", exp_pix.addr, pix.addr);
                    compare_value("pix.value", exp_pix.value, pix.value);
                end
                pix_total = pix_total + 1;
            end
            if (done)
            begin
                assert (prev_pix_valid && exp_q.size() == 0 &&
                        pix_total == runs_started * NUM_ANGLES * LINE_LEN)
                    else abort_run("done did not follow the final update of the run");
                done_cnt = done_cnt + 1;
            end
            prev_pix_valid = pix_valid;
        end
    end

    // proj_ready only inside the fill window
    assert property (@(posedge clk) disable iff (!reset_n)
                     proj_ready == (uut.u_state_control.state == FILL))
        else abort_run("proj_ready does not match the fill phase");

    assert property (@(posedge clk) disable iff (!reset_n)
                     done |-> $past(pix_valid) && !pix_valid)
        else abort_run("done is not one cycle after the last pixel update");

    // swap ack follows the request by one cycle and lasts one cycle
    assert property (@(posedge clk) disable iff (!reset_n)
                     $rose(uut.sw_swap) |=> uut.sw_swap_ack ##1 !uut.sw_swap_ack)
        else abort_run("swap acknowledge did not follow the swap request by one cycle");

    initial
    begin
        angle_param_t p;
        int           a;
        reset_n        = 1'b0;
        cfg_valid      = 1'b0;
        cfg_index      = '0;
        cfg_param      = '0;
        start          = 1'b0;
        proj_valid     = 1'b0;
        proj_sample    = '0;
        lfsr           = 32'h8c43_dd1a;
        pix_total      = 0;
        done_cnt       = 0;
        runs_started   = 0;
        run_started    = 1'b0;
        prev_pix_valid = 1'b0;
        repeat (10) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        for (a = 0; a < NUM_ANGLES; a++)
            write_entry(a, random_param());

        // stray samples before any run
        repeat (4)
        begin
            proj_valid  = 1'b1;
            proj_sample = sample_t'(lfsr_bits(SAMPLE_W));
            @(negedge clk);
        end
        proj_valid = 1'b0;
        repeat (3) @(negedge clk);
        run_angles();

        // zero offset, full wrap offset with address wrap, constant address
        p              = random_param();
        p.sh_accu_base = '0;
        write_entry(0, p);
        p.sh_accu_base = offset_t'(LINE_LEN - 1);
        p.mp_accu_init = 12'hffa;
        p.mp_accu_base = 12'h9c3;
        write_entry(1, p);
        p              = random_param();
        p.mp_accu_base = '0;
        write_entry(2, p);
        write_entry(3, random_param());
        run_angles();

        repeat (10) @(negedge clk);
        if (pix_total == 2 * NUM_ANGLES * LINE_LEN && done_cnt == 2 && exp_q.size() == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            abort_run("update or done count is wrong at the end of the test");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/nabp_pkg.sv
hdl/nabp_swap_control.sv
hdl/nabp_state_control.sv
hdl/nabp_shifter.sv
hdl/nabp_mapper.sv
hdl/nabp_top.sv
dv/nabp_tb.sv
